//--- rv_isa_pkg.sv
// M-extension encoding for RV32/RV64 with a 32-entry register file and 16 commit ids in flight

package rv_isa_pkg;

    // width of an architectural register address
    localparam int REG_ADDR_W = 5;

    // width of the commit id handed out by dispatch
    localparam int COMMIT_ID_W = 4;

    // funct3 of the M extension
    // bit 2 picks the divider, bits 1:0 are the variant inside a unit
    typedef enum logic [2:0] {
        // low word of the signed product
        MD_MUL    = 3'd0,
        // high word, both operands signed
        MD_MULH   = 3'd1,
        // high word, rs1 signed and rs2 unsigned
        MD_MULHSU = 3'd2,
        // high word, both operands unsigned
        MD_MULHU  = 3'd3,
        // signed quotient
        MD_DIV    = 3'd4,
        // unsigned quotient
        MD_DIVU   = 3'd5,
        // signed remainder
        MD_REM    = 3'd6,
        // unsigned remainder
        MD_REMU   = 3'd7
    } md_op_e;

endpackage

//--- muldiv_pkg.sv
// Payload fields are 64 bits wide and only the low XLEN bits carry data at narrower XLEN

package muldiv_pkg;

    // fixed width of every data field, wide enough for RV64
    localparam int DATA_W = 64;

    // destination of a result
    typedef struct packed {
        logic [rv_isa_pkg::REG_ADDR_W-1:0]  rd;
        logic [rv_isa_pkg::COMMIT_ID_W-1:0] commit_id;
    } md_tag_t;

    // request from dispatch, held until accepted
    typedef struct packed {
        rv_isa_pkg::md_op_e op;
        logic [DATA_W-1:0]  rs1_data;
        logic [DATA_W-1:0]  rs2_data;
        md_tag_t            tag;
    } md_req_t;

    // start command to one arithmetic unit
    // variant is funct3[1:0], meaning depends on the unit
    typedef struct packed {
        logic [1:0]        variant;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } md_cmd_t;

    // register file write
    typedef struct packed {
        logic [DATA_W-1:0] data;
        md_tag_t           tag;
    } md_wb_t;

endpackage

//--- muldiv_multiplier.sv
// Shift-add multiplier taking XLEN+1 cycles from start to done with no early-out and no abort

module muldiv_multiplier #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                start_i,
    input  muldiv_pkg::md_cmd_t cmd_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [63:0]         result_o
);

    localparam int CNT_W = $clog2(XLEN + 1);

    logic              a_signed;
    logic              b_signed;
    logic [2*XLEN-1:0] a_wide;
    logic [XLEN:0]     b_ext;
    logic [2*XLEN-1:0] acc_q;
    logic [2*XLEN-1:0] mcand_q;
    logic [2*XLEN-1:0] addend;
    logic [XLEN:0]     mplier_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              low_word_q;
    logic              last_step;

    // operand extension to XLEN+1 bits per variant
    assign a_signed = cmd_i.variant != 2'(rv_isa_pkg::MD_MULHU);
    assign b_signed = (cmd_i.variant == 2'(rv_isa_pkg::MD_MUL)) ||
                      (cmd_i.variant == 2'(rv_isa_pkg::MD_MULH));

    // only 2*XLEN product bits are kept, so the wrap is harmless
    assign a_wide = {{XLEN{a_signed & cmd_i.a[XLEN-1]}}, cmd_i.a[XLEN-1:0]};
    assign b_ext  = {b_signed & cmd_i.b[XLEN-1], cmd_i.b[XLEN-1:0]};

    assign addend    = mplier_q[0] ? mcand_q : '0;
    assign last_step = cnt_q == CNT_W'(XLEN);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_o <= busy_o & last_step;
            if (start_i) begin
                busy_o <= 1'b1;
                cnt_q  <= CNT_W'(1);
            end else if (busy_o) begin
                cnt_q <= cnt_q + CNT_W'(1);
                if (last_step) begin
                    busy_o <= 1'b0;
                end
            end
        end
    end

    // bit 0 is added while loading, bits 1..XLEN follow one per cycle
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q      <= b_ext[0] ? a_wide : '0;
            mcand_q    <= a_wide << 1;
            mplier_q   <= b_ext >> 1;
            low_word_q <= cmd_i.variant == 2'(rv_isa_pkg::MD_MUL);
        end else if (busy_o) begin
            // extension bit has negative weight
            acc_q    <= last_step ? acc_q - addend : acc_q + addend;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    always_comb begin
        result_o = '0;
        result_o[XLEN-1:0] = low_word_q ? acc_q[XLEN-1:0] : acc_q[2*XLEN-1:XLEN];
    end

endmodule

//--- muldiv_divider.sv
// Restoring divider taking XLEN+1 cycles from start to done for every operand including zero divisors

module muldiv_divider #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                start_i,
    input  muldiv_pkg::md_cmd_t cmd_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [63:0]         result_o
);

    localparam int CNT_W = $clog2(XLEN + 1);

    logic              is_signed;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_val;
    logic [XLEN-1:0]   b_val;
    logic [XLEN-1:0]   a_abs;
    logic [XLEN-1:0]   b_abs;
    logic [XLEN-1:0]   quo_q;
    logic [XLEN-1:0]   rem_q;
    logic [XLEN-1:0]   dvsr_q;
    logic              q_neg_q;
    logic              r_neg_q;
    logic              want_rem_q;
    logic [XLEN:0]     shifted;
    logic [XLEN:0]     trial;
    logic [XLEN-1:0]   q_fix;
    logic [XLEN-1:0]   r_fix;
    logic [CNT_W-1:0]  cnt_q;
    logic              last_step;

    assign a_val     = cmd_i.a[XLEN-1:0];
    assign b_val     = cmd_i.b[XLEN-1:0];
    assign is_signed = (cmd_i.variant == 2'(rv_isa_pkg::MD_DIV)) ||
                       (cmd_i.variant == 2'(rv_isa_pkg::MD_REM));
    assign a_neg     = is_signed & a_val[XLEN-1];
    assign b_neg     = is_signed & b_val[XLEN-1];
    assign a_abs     = a_neg ? -a_val : a_val;
    assign b_abs     = b_neg ? -b_val : b_val;

    // next dividend bit enters the partial remainder
    assign shifted   = {rem_q, quo_q[XLEN-1]};
    assign trial     = shifted - {1'b0, dvsr_q};
    assign last_step = cnt_q == CNT_W'(XLEN - 1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_o <= busy_o & last_step;
            if (start_i) begin
                busy_o <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_o) begin
                cnt_q <= cnt_q + CNT_W'(1);
                if (last_step) begin
                    busy_o <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q      <= a_abs;
            rem_q      <= '0;
            dvsr_q     <= b_abs;
            // a zero divisor keeps the all-ones quotient unsigned
            q_neg_q    <= (a_neg ^ b_neg) & (b_val != '0);
            r_neg_q    <= a_neg;
            want_rem_q <= cmd_i.variant[1];
        end else if (busy_o) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix after the loop
    // divide by zero leaves all ones and the dividend magnitude
    // overflow comes out as 2^(XLEN-1) with remainder 0
    assign q_fix = q_neg_q ? -quo_q : quo_q;
    assign r_fix = r_neg_q ? -rem_q : rem_q;

    always_comb begin
        result_o = '0;
        result_o[XLEN-1:0] = want_rem_q ? r_fix : q_fix;
    end

endmodule

//--- muldiv_ctrl.sv
// One operation per unit in flight and no cancel, so an interrupt only blocks new starts

module muldiv_ctrl #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_valid_i,
    input  muldiv_pkg::md_req_t req_i,
    input  logic                int_assert_i,
    input  logic                wb_ready_i,
    input  logic                mul_busy_i,
    input  logic                mul_done_i,
    input  logic [63:0]         mul_result_i,
    input  logic                div_busy_i,
    input  logic                div_done_i,
    input  logic [63:0]         div_result_i,
    output logic                mul_start_o,
    output muldiv_pkg::md_cmd_t mul_cmd_o,
    output logic                div_start_o,
    output muldiv_pkg::md_cmd_t div_cmd_o,
    output logic                stall_o,
    output logic                wb_valid_o,
    output muldiv_pkg::md_wb_t  wb_o
);

    logic                 is_div;
    logic                 mul_blocked;
    logic                 div_blocked;
    logic                 accept;
    muldiv_pkg::md_cmd_t  cmd;

    logic                 mul_pend_q;
    logic                 div_pend_q;
    logic                 div_held_q;
    muldiv_pkg::md_tag_t  mul_tag_q;
    muldiv_pkg::md_tag_t  div_tag_q;
    logic [XLEN-1:0]      mul_res_q;
    logic [XLEN-1:0]      div_res_q;
    logic                 sel_mul;
    logic                 wb_fire;

    assign is_div = req_i.op[2];

    // the done cycle counts as holding a result
    assign mul_blocked = mul_busy_i | mul_done_i | mul_pend_q;
    assign div_blocked = div_busy_i | div_done_i | div_pend_q;

    assign stall_o = req_valid_i & (is_div ? div_blocked : mul_blocked);
    assign accept  = req_valid_i & ~stall_o & ~int_assert_i;

    assign mul_start_o = accept & ~is_div;
    assign div_start_o = accept & is_div;

    // both units see the same command, the start strobe picks one
    always_comb begin
        cmd = '0;
        cmd.variant = req_i.op[1:0];
        cmd.a[XLEN-1:0] = req_i.rs1_data[XLEN-1:0];
        cmd.b[XLEN-1:0] = req_i.rs2_data[XLEN-1:0];
    end

    assign mul_cmd_o = cmd;
    assign div_cmd_o = cmd;

    // multiply goes first unless a divide result is already on the port
    assign sel_mul    = mul_pend_q & ~div_held_q;
    assign wb_valid_o = mul_pend_q | div_pend_q;
    assign wb_fire    = wb_valid_o & wb_ready_i;

    always_comb begin
        wb_o = '0;
        if (sel_mul) begin
            wb_o.data[XLEN-1:0] = mul_res_q;
            wb_o.tag = mul_tag_q;
        end else begin
            wb_o.data[XLEN-1:0] = div_res_q;
            wb_o.tag = div_tag_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mul_pend_q <= 1'b0;
            div_pend_q <= 1'b0;
            div_held_q <= 1'b0;
        end else begin
            if (mul_done_i) begin
                mul_pend_q <= 1'b1;
            end else if (wb_fire && sel_mul) begin
                mul_pend_q <= 1'b0;
            end
            if (div_done_i) begin
                div_pend_q <= 1'b1;
            end else if (wb_fire && !sel_mul) begin
                div_pend_q <= 1'b0;
            end
            // keep wb_o stable while a shown divide waits
            div_held_q <= wb_valid_o & ~sel_mul & ~wb_ready_i;
        end
    end

    // tags on start, results on done
    always_ff @(posedge clk) begin
        if (mul_start_o) begin
            mul_tag_q <= req_i.tag;
        end
        if (div_start_o) begin
            div_tag_q <= req_i.tag;
        end
        if (mul_done_i) begin
            mul_res_q <= mul_result_i[XLEN-1:0];
        end
        if (div_done_i) begin
            div_res_q <= div_result_i[XLEN-1:0];
        end
    end

endmodule

//--- muldiv_unit.sv
// XLEN is 32 or 64 and the register file write port must accept the held wb_o when ready

module muldiv_unit #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_valid_i,
    input  muldiv_pkg::md_req_t req_i,
    input  logic                int_assert_i,
    input  logic                wb_ready_i,
    output logic                stall_o,
    output logic                wb_valid_o,
    output muldiv_pkg::md_wb_t  wb_o
);

    logic                mul_start;
    logic                mul_busy;
    logic                mul_done;
    logic [63:0]         mul_result;
    muldiv_pkg::md_cmd_t mul_cmd;
    logic                div_start;
    logic                div_busy;
    logic                div_done;
    logic [63:0]         div_result;
    muldiv_pkg::md_cmd_t div_cmd;

    muldiv_ctrl #(
        .XLEN(XLEN)
    ) u_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .int_assert_i(int_assert_i),
        .wb_ready_i  (wb_ready_i),
        .mul_busy_i  (mul_busy),
        .mul_done_i  (mul_done),
        .mul_result_i(mul_result),
        .div_busy_i  (div_busy),
        .div_done_i  (div_done),
        .div_result_i(div_result),
        .mul_start_o (mul_start),
        .mul_cmd_o   (mul_cmd),
        .div_start_o (div_start),
        .div_cmd_o   (div_cmd),
        .stall_o     (stall_o),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

    muldiv_multiplier #(
        .XLEN(XLEN)
    ) u_mul (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (mul_start),
        .cmd_i   (mul_cmd),
        .busy_o  (mul_busy),
        .done_o  (mul_done),
        .result_o(mul_result)
    );

    muldiv_divider #(
        .XLEN(XLEN)
    ) u_div (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (div_start),
        .cmd_i   (div_cmd),
        .busy_o  (div_busy),
        .done_o  (div_done),
        .result_o(div_result)
    );

endmodule

//--- tb_muldiv_checker.sv
// Models M-extension results for XLEN up to 64 and needs commit ids unique among requests in flight

module tb_muldiv_checker #(
    parameter int XLEN = 32
) (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  req_valid_i,
    input  muldiv_pkg::md_req_t                   req_i,
    input  logic                                  int_assert_i,
    input  logic                                  stall_i,
    input  logic                                  wb_ready_i,
    input  logic                                  wb_valid_i,
    input  muldiv_pkg::md_wb_t                    wb_i,
    output int                                    errors_o,
    output int                                    checks_o,
    output int                                    writebacks_o,
    output logic [2**rv_isa_pkg::COMMIT_ID_W-1:0] in_flight_o
);

    localparam int NUM_IDS = 2 ** rv_isa_pkg::COMMIT_ID_W;
    localparam logic [63:0] MASK = {64{1'b1}} >> (64 - XLEN);
    localparam logic [63:0] MIN_NEG = 64'd1 << (XLEN - 1);

    int                                errors = 0;
    int                                checks = 0;
    int                                writebacks = 0;
    logic [63:0]                       exp_data [NUM_IDS];
    logic [rv_isa_pkg::REG_ADDR_W-1:0] exp_rd [NUM_IDS];
    logic [NUM_IDS-1:0]                in_flight;
    logic [rv_isa_pkg::COMMIT_ID_W-1:0] req_id;
    logic [rv_isa_pkg::COMMIT_ID_W-1:0] wb_id;

    // funct3 rules of the M extension with a 128-bit product so XLEN 64 fits
    function automatic logic [63:0] model_result(logic [2:0] op, logic [63:0] rs1,
                                                 logic [63:0] rs2);
        logic [63:0]  a;
        logic [63:0]  b;
        logic [63:0]  a_mag;
        logic [63:0]  b_mag;
        logic [127:0] a_ext;
        logic [127:0] b_ext;
        logic [127:0] prod;
        logic         a_neg;
        logic         b_neg;
        a = rs1 & MASK;
        b = rs2 & MASK;
        // rs1 unsigned only for MULHU, DIVU, REMU
        a_neg = a[XLEN-1] && op != 3'd3 && op != 3'd5 && op != 3'd7;
        b_neg = b[XLEN-1] && (op == 3'd0 || op == 3'd1 || op == 3'd4 || op == 3'd6);
        if (!op[2]) begin
            a_ext = a_neg ? ({64'd0, a} | ~{64'd0, MASK}) : {64'd0, a};
            b_ext = b_neg ? ({64'd0, b} | ~{64'd0, MASK}) : {64'd0, b};
            prod = a_ext * b_ext;
            if (op == 3'd0) begin
                return prod[63:0] & MASK;
            end
            return prod[XLEN +: 64] & MASK;
        end
        // divide by zero gives all ones and the dividend as remainder
        if (b == 64'd0) begin
            return op[1] ? a : MASK;
        end
        // signed overflow
        if (a_neg && b_neg && a == MIN_NEG && b == MASK) begin
            return op[1] ? 64'd0 : MIN_NEG;
        end
        a_mag = a_neg ? (-a) & MASK : a;
        b_mag = b_neg ? (-b) & MASK : b;
        if (op[1]) begin
            return a_neg ? (-(a_mag % b_mag)) & MASK : a_mag % b_mag;
        end
        return (a_neg ^ b_neg) ? (-(a_mag / b_mag)) & MASK : a_mag / b_mag;
    endfunction

    task automatic compare_field(string name, int id, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s (commit id %0d): got 0x%h, expected 0x%h", name, id, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            in_flight = '0;
        end else begin
            if (wb_valid_i && wb_ready_i) begin
                wb_id = wb_i.tag.commit_id;
                writebacks++;
                if (!in_flight[wb_id]) begin
                    errors++;
                    $display("writeback for commit id %0d that has no accepted request", wb_id);
                end else begin
                    compare_field("wb_o.data", int'(wb_id), wb_i.data, exp_data[wb_id]);
                    compare_field("wb_o.tag.rd", int'(wb_id), 64'(wb_i.tag.rd),
                                  64'(exp_rd[wb_id]));
                    in_flight[wb_id] = 1'b0;
                end
            end
            // acceptance rule of the dispatch handshake
            if (req_valid_i && !stall_i && !int_assert_i) begin
                req_id = req_i.tag.commit_id;
                if (in_flight[req_id]) begin
                    errors++;
                    $display("commit id %0d accepted again while still in flight", req_id);
                end
                exp_data[req_id]  = model_result(req_i.op, req_i.rs1_data, req_i.rs2_data);
                exp_rd[req_id]    = req_i.tag.rd;
                in_flight[req_id] = 1'b1;
            end
        end
    end

    assign errors_o     = errors;
    assign checks_o     = checks;
    assign writebacks_o = writebacks;
    assign in_flight_o  = in_flight;

endmodule

//--- tb_muldiv_unit.sv
// Runs at XLEN 32 and presents one request at a time, held until the DUT accepts it

module tb_muldiv_unit;

    localparam int XLEN    = 32;
    localparam int TIMEOUT = 300;
    localparam int NUM_IDS = 2 ** rv_isa_pkg::COMMIT_ID_W;

    logic                clk;
    logic                rst_i;
    logic                req_valid_i;
    muldiv_pkg::md_req_t req_i;
    logic                int_assert_i;
    logic                wb_ready_i;
    logic                stall_o;
    logic                wb_valid_o;
    muldiv_pkg::md_wb_t  wb_o;
    muldiv_pkg::md_wb_t  held_wb;
    logic [NUM_IDS-1:0]  in_flight;
    logic                ready_next;
    logic                int_next;
    int                  chk_errors;
    int                  chk_checks;
    int                  chk_writebacks;
    int                  seed = 32'h7d6f;
    int                  tb_errors = 0;
    int                  tb_checks = 0;
    int                  next_id = 0;
    // 0 random, 1 low, 2 high
    int                  ready_mode = 2;
    // 0 off, 1 random, 2 high
    int                  int_mode = 0;

    muldiv_unit #(.XLEN(XLEN)) i_dut (
        .clk(clk), .rst_i(rst_i), .req_valid_i(req_valid_i), .req_i(req_i),
        .int_assert_i(int_assert_i), .wb_ready_i(wb_ready_i), .stall_o(stall_o),
        .wb_valid_o(wb_valid_o), .wb_o(wb_o)
    );

    tb_muldiv_checker #(.XLEN(XLEN)) u_checker (
        .clk(clk), .rst_i(rst_i), .req_valid_i(req_valid_i), .req_i(req_i),
        .int_assert_i(int_assert_i), .stall_i(stall_o), .wb_ready_i(wb_ready_i),
        .wb_valid_i(wb_valid_o), .wb_i(wb_o), .errors_o(chk_errors), .checks_o(chk_checks),
        .writebacks_o(chk_writebacks), .in_flight_o(in_flight)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // zero, -1 and the most negative value on purpose
    function automatic logic [63:0] pick_operand();
        case (rand_below(8))
            0: return 64'd0;
            1: return '1;
            2: return 64'd1 << (XLEN - 1);
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        tb_checks++;
        if (got !== exp) begin
            tb_errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // tasks start and end on a falling edge
    task automatic present_request(logic [2:0] op, logic [63:0] a, logic [63:0] b);
        req_valid_i         = 1'b1;
        req_i.op            = rv_isa_pkg::md_op_e'(op);
        req_i.rs1_data      = a;
        req_i.rs2_data      = b;
        req_i.tag.rd        = 5'(rand_below(32));
        req_i.tag.commit_id = 4'(next_id);
        next_id             = (next_id + 1) % NUM_IDS;
    endtask

    task automatic await_accept();
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < TIMEOUT) begin
            @(posedge clk);
            accepted = !stall_o && !int_assert_i;
            waited++;
        end
        @(negedge clk);
        req_valid_i = 1'b0;
        if (!accepted) begin
            tb_errors++;
            $display("request with commit id %0d was never accepted", req_i.tag.commit_id);
        end
    endtask

    task automatic issue_request(logic [2:0] op, logic [63:0] a, logic [63:0] b);
        present_request(op, a, b);
        await_accept();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (in_flight != '0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        for (int i = 0; i < NUM_IDS; i++) begin
            if (in_flight[i]) begin
                tb_errors++;
                $display("timeout: commit id %0d never wrote back", i);
            end
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        int new_errors;
        new_errors = tb_errors + chk_errors - errors_before;
        if (new_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, new_errors);
        end
    endtask

    initial begin
        int base;
        int waited;
        int wbs_before;
        rst_i        = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        wb_ready_i   = 1'b0;
        int_assert_i = 1'b0;
        // write-port ready and interrupts in the background
        // drawn at the rising edge and driven at the falling edge
        fork
            forever begin
                @(posedge clk);
                ready_next = ready_mode == 2 || (ready_mode == 0 && rand_below(4) != 0);
                int_next   = int_mode == 2 || (int_mode == 1 && rand_below(8) == 0);
                @(negedge clk);
                wb_ready_i   = ready_next;
                int_assert_i = int_next;
            end
        join_none
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        base = tb_errors + chk_errors;
        repeat (4) begin
            @(posedge clk);
            check_value("wb_valid_o", 64'(wb_valid_o), 64'd0);
            check_value("stall_o", 64'(stall_o), 64'd0);
        end
        @(negedge clk);
        finish_test("reset state", base);

        ready_mode = 0;
        int_mode   = 1;
        base = tb_errors + chk_errors;
        repeat (40) issue_request(3'(rand_below(4)), pick_operand(), pick_operand());
        drain();
        finish_test("multiply", base);

        base = tb_errors + chk_errors;
        issue_request(3'd4, 64'd1 << (XLEN - 1), '1);
        issue_request(3'd6, 64'd1 << (XLEN - 1), '1);
        issue_request(3'd5, pick_operand(), 64'd0);
        issue_request(3'd6, pick_operand(), 64'd0);
        repeat (40) issue_request(3'(4 + rand_below(4)), pick_operand(), pick_operand());
        drain();
        finish_test("divide and remainder", base);

        base = tb_errors + chk_errors;
        repeat (20) begin
            issue_request(3'(rand_below(4)), pick_operand(), pick_operand());
            issue_request(3'(4 + rand_below(4)), pick_operand(), pick_operand());
            if ($countones(in_flight) != 2) begin
                tb_errors++;
                $display("multiply and divide were not in flight together");
            end
        end
        drain();
        finish_test("overlap", base);

        ready_mode = 1;
        int_mode   = 0;
        base = tb_errors + chk_errors;
        issue_request(3'd4, pick_operand(), pick_operand());
        waited = 0;
        while (!wb_valid_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_valid_o) begin
            tb_errors++;
            $display("divide result never showed on the write port");
        end
        held_wb = wb_o;
        // a multiply finishing behind the shown divide leaves wb_o alone
        issue_request(3'd0, pick_operand(), pick_operand());
        // a second divide stalls behind the unwritten result
        present_request(3'd5, pick_operand(), pick_operand());
        repeat (XLEN + 8) begin
            @(posedge clk);
            check_value("stall_o", 64'(stall_o), 64'd1);
            check_value("wb_valid_o", 64'(wb_valid_o), 64'd1);
            check_value("wb_o.data", wb_o.data, held_wb.data);
            check_value("wb_o.tag", 64'(wb_o.tag), 64'(held_wb.tag));
        end
        @(negedge clk);
        ready_mode = 2;
        await_accept();
        drain();
        finish_test("back-pressure", base);

        int_mode = 2;
        base = tb_errors + chk_errors;
        @(negedge clk);
        wbs_before = chk_writebacks;
        present_request(3'd4, pick_operand(), pick_operand());
        repeat (20) @(negedge clk);
        req_valid_i = 1'b0;
        int_mode    = 0;
        repeat (XLEN + 10) @(negedge clk);
        if (chk_writebacks != wbs_before) begin
            tb_errors++;
            $display("request presented during an interrupt wrote back");
        end
        finish_test("interrupt block", base);

        $display("%0d checks, %0d errors", chk_checks + tb_checks, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- muldiv_unit.f
rv_isa_pkg.sv
muldiv_pkg.sv
muldiv_multiplier.sv
muldiv_divider.sv
muldiv_ctrl.sv
muldiv_unit.sv
tb_muldiv_checker.sv
tb_muldiv_unit.sv

//--- run_sim.sh
#!/bin/sh
# builds with Verilator from the project root and runs the testbench once
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_muldiv_unit -f muldiv_unit.f -o sim_muldiv_unit || exit 1
out=$(./obj_dir/sim_muldiv_unit)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
